/* design/rot_pkg.sv */
// Rotator subsystem package with word width, APB register map, command codes and bus structs
package rot_pkg;

  // Rotator word
  localparam int ROT_WIDTH = 100;

  // APB address and data widths
  localparam int APB_AW = 12;
  localparam int APB_DW = 32;

  // Bits of the staged word and of q that land in the fourth register
  localparam int TOP_W = ROT_WIDTH - 3 * APB_DW;

  // Width of the CMD step count field
  localparam int CNT_W = 8;

  // Register byte addresses
  localparam logic [APB_AW-1:0] ADDR_DATA0  = 12'h000;
  localparam logic [APB_AW-1:0] ADDR_DATA1  = 12'h004;
  localparam logic [APB_AW-1:0] ADDR_DATA2  = 12'h008;
  localparam logic [APB_AW-1:0] ADDR_DATA3  = 12'h00C;
  localparam logic [APB_AW-1:0] ADDR_CTRL   = 12'h010;
  localparam logic [APB_AW-1:0] ADDR_CMD    = 12'h014;
  localparam logic [APB_AW-1:0] ADDR_STATUS = 12'h018;
  localparam logic [APB_AW-1:0] ADDR_Q0     = 12'h020;
  localparam logic [APB_AW-1:0] ADDR_Q1     = 12'h024;
  localparam logic [APB_AW-1:0] ADDR_Q2     = 12'h028;
  localparam logic [APB_AW-1:0] ADDR_Q3     = 12'h02C;

  // Core enable codes; the same code picks the q source
  localparam logic [1:0] ENA_DATA   = 2'b00;
  localparam logic [1:0] ENA_LEFT   = 2'b01;
  localparam logic [1:0] ENA_RIGHT  = 2'b10;
  localparam logic [1:0] ENA_STAGE3 = 2'b11;

  // Operation field of CMD
  typedef enum logic [1:0] {
    OP_NONE  = 2'b00,
    OP_LOAD  = 2'b01,
    OP_LEFT  = 2'b10,
    OP_RIGHT = 2'b11
  } rot_op_e;

  // APB request from the bus master
  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
  } apb_req_t;

  // APB response back to the master
  typedef struct packed {
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  // Core controls from the register block
  typedef struct packed {
    logic       load;
    logic [1:0] ena;
  } rot_ctrl_t;

endpackage

/* design/rot_regs.sv */
// Rotator register block: APB slave, input word staging and command step sequencer
`timescale 1ns/1ps

module rot_regs (
  input  logic                          clk,
  input  logic                          rst_n,
  input  rot_pkg::apb_req_t             apb_req,
  output rot_pkg::apb_rsp_t             apb_rsp,
  output rot_pkg::rot_ctrl_t            ctrl,
  output logic [rot_pkg::ROT_WIDTH-1:0] data,
  input  logic [rot_pkg::ROT_WIDTH-1:0] q
);

  import rot_pkg::*;

  // APB access decode
  logic              access;
  logic              rd_req;
  logic              acc_err;
  logic              wr_ok;
  logic [APB_DW-1:0] rd_word;

  // Register state
  logic [ROT_WIDTH-1:0] data_r;
  logic                 idle_view;

  // Command sequencer
  rot_op_e              cmd_op;
  logic [CNT_W-1:0]     cmd_cnt;
  logic                 cmd_wr;
  logic                 load_r;
  logic [CNT_W-1:0]     step_cnt;
  logic [1:0]           step_ena;
  logic                 busy;

  assign access = apb_req.psel && apb_req.penable;
  assign rd_req = access && !apb_req.pwrite;
  assign wr_ok  = access && apb_req.pwrite && !acc_err;

  // Address decode, read mux and error check share one case
  always_comb begin
    acc_err = 1'b0;
    rd_word = '0;
    case (apb_req.paddr)
      ADDR_DATA0: rd_word = data_r[APB_DW-1:0];
      ADDR_DATA1: rd_word = data_r[2*APB_DW-1:APB_DW];
      ADDR_DATA2: rd_word = data_r[3*APB_DW-1:2*APB_DW];
      ADDR_DATA3: rd_word = APB_DW'(data_r[ROT_WIDTH-1:3*APB_DW]);
      ADDR_CTRL:  rd_word = APB_DW'(idle_view);
      // CMD reads as zero; a new command is refused while one runs
      ADDR_CMD:   acc_err = apb_req.pwrite && busy;
      ADDR_STATUS: begin
        rd_word = APB_DW'(busy);
        acc_err = apb_req.pwrite;
      end
      ADDR_Q0: begin
        rd_word = q[APB_DW-1:0];
        acc_err = apb_req.pwrite;
      end
      ADDR_Q1: begin
        rd_word = q[2*APB_DW-1:APB_DW];
        acc_err = apb_req.pwrite;
      end
      ADDR_Q2: begin
        rd_word = q[3*APB_DW-1:2*APB_DW];
        acc_err = apb_req.pwrite;
      end
      ADDR_Q3: begin
        rd_word = APB_DW'(q[ROT_WIDTH-1:3*APB_DW]);
        acc_err = apb_req.pwrite;
      end
      default: acc_err = 1'b1;
    endcase
  end

  // No wait states, so pready stays high
  always_comb begin
    apb_rsp.prdata  = rd_req ? rd_word : '0;
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = access && acc_err;
  end

  // Staged input word and view select
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_r    <= '0;
      idle_view <= 1'b0;
    end else if (wr_ok) begin
      case (apb_req.paddr)
        ADDR_DATA0: data_r[APB_DW-1:0]          <= apb_req.pwdata;
        ADDR_DATA1: data_r[2*APB_DW-1:APB_DW]   <= apb_req.pwdata;
        ADDR_DATA2: data_r[3*APB_DW-1:2*APB_DW] <= apb_req.pwdata;
        // Only the low bits of DATA3 exist
        ADDR_DATA3: data_r[ROT_WIDTH-1:3*APB_DW] <= apb_req.pwdata[TOP_W-1:0];
        ADDR_CTRL:  idle_view <= apb_req.pwdata[0];
        default: ;
      endcase
    end
  end

  assign data = data_r;

  // CMD fields: op in bits 1:0, count in bits 15:8
  assign cmd_op  = rot_op_e'(apb_req.pwdata[1:0]);
  assign cmd_cnt = apb_req.pwdata[8 +: CNT_W];
  assign cmd_wr  = wr_ok && (apb_req.paddr == ADDR_CMD);

  // One load pulse, or a run of cnt steps in the latched direction
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      load_r   <= 1'b0;
      step_cnt <= '0;
      step_ena <= ENA_DATA;
    end else begin
      load_r <= 1'b0;
      if (step_cnt != '0) begin
        step_cnt <= step_cnt - 1'b1;
      end
      if (cmd_wr) begin
        case (cmd_op)
          OP_LOAD: load_r <= 1'b1;
          OP_LEFT, OP_RIGHT: begin
            // Zero count is a no-op
            if (cmd_cnt != '0) begin
              step_cnt <= cmd_cnt;
              step_ena <= (cmd_op == OP_LEFT) ? ENA_LEFT : ENA_RIGHT;
            end
          end
          default: ;
        endcase
      end
    end
  end

  assign busy = load_r || (step_cnt != '0);

  // Idle enable follows idle_view, so q shows stage 3 or the staged word
  always_comb begin
    ctrl.load = load_r;
    if (step_cnt != '0) begin
      ctrl.ena = step_ena;
    end else if (idle_view) begin
      ctrl.ena = ENA_STAGE3;
    end else begin
      ctrl.ena = ENA_DATA;
    end
  end

endmodule

/* design/rot_core.sv */
// Rotator core: three-stage load and rotate register bank with enable-selected output
`timescale 1ns/1ps

module rot_core (
  input  logic                          clk,
  input  logic                          rst_n,
  input  rot_pkg::rot_ctrl_t            ctrl,
  input  logic [rot_pkg::ROT_WIDTH-1:0] data,
  output logic [rot_pkg::ROT_WIDTH-1:0] q
);

  import rot_pkg::*;

  logic [ROT_WIDTH-1:0] stage1_data;
  logic [ROT_WIDTH-1:0] stage2_data;
  logic [ROT_WIDTH-1:0] stage3_data;

  // Rotate toward the MSB by n bits
  function automatic logic [ROT_WIDTH-1:0] rotl(
    input logic [ROT_WIDTH-1:0] x,
    input int unsigned          n
  );
    return (x << n) | (x >> (ROT_WIDTH - n));
  endfunction

  // Rotate toward the LSB by n bits
  function automatic logic [ROT_WIDTH-1:0] rotr(
    input logic [ROT_WIDTH-1:0] x,
    input int unsigned          n
  );
    return (x >> n) | (x << (ROT_WIDTH - n));
  endfunction

  // Load wins over any rotate request
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage1_data <= '0;
      stage2_data <= '0;
      stage3_data <= '0;
    end else if (ctrl.load) begin
      stage1_data <= data;
      stage2_data <= stage1_data;
      stage3_data <= stage2_data;
    end else begin
      case (ctrl.ena)
        ENA_LEFT: begin
          stage1_data <= rotl(stage1_data, 1);
          stage2_data <= rotl(stage2_data, 2);
          stage3_data <= rotl(stage3_data, 3);
        end
        ENA_RIGHT: begin
          stage1_data <= rotr(stage1_data, 1);
          stage2_data <= rotr(stage2_data, 2);
          stage3_data <= rotr(stage3_data, 3);
        end
        // 00 and 11 hold
        default: ;
      endcase
    end
  end

  // Output select follows ena directly
  always_comb begin
    case (ctrl.ena)
      ENA_DATA:  q = data;
      ENA_LEFT:  q = stage1_data;
      ENA_RIGHT: q = stage2_data;
      default:   q = stage3_data;
    endcase
  end

endmodule

/* design/rot_top.sv */
// Rotator subsystem top joining the APB register block and the rotator core
`timescale 1ns/1ps

module rot_top (
  input  logic              clk,
  input  logic              rst_n,
  input  rot_pkg::apb_req_t apb_req,
  output rot_pkg::apb_rsp_t apb_rsp
);

  import rot_pkg::*;

  rot_ctrl_t            ctrl;
  logic [ROT_WIDTH-1:0] data;
  logic [ROT_WIDTH-1:0] q;

  // Register front end and command sequencer
  rot_regs regs_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .ctrl    (ctrl),
    .data    (data),
    .q       (q)
  );

  // Three-stage rotator
  rot_core core_i (
    .clk   (clk),
    .rst_n (rst_n),
    .ctrl  (ctrl),
    .data  (data),
    .q     (q)
  );

endmodule

/* verification/rot_clk_gen.sv */
// Testbench clock and reset source with a fixed period and reset length
`timescale 1ns/1ps

module rot_clk_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset is released on a rising edge
  initial begin
    rst_n <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* verification/rot_props.sv */
// Rotator core assertions on controls, output select, load shift and rotation
`timescale 1ns/1ps

module rot_props (
  input logic                          clk,
  input logic                          rst_n,
  input rot_pkg::rot_ctrl_t            ctrl,
  input logic [rot_pkg::ROT_WIDTH-1:0] data,
  input logic [rot_pkg::ROT_WIDTH-1:0] q,
  input logic [rot_pkg::ROT_WIDTH-1:0] stage1_data,
  input logic [rot_pkg::ROT_WIDTH-1:0] stage2_data,
  input logic [rot_pkg::ROT_WIDTH-1:0] stage3_data
);

  import rot_pkg::*;

  localparam int W = ROT_WIDTH;

  logic [W-1:0]   sel_q;
  logic [3*W-1:0] stages;
  logic [3*W-1:0] left_next;
  logic [3*W-1:0] right_next;

  // Failed assertion count, read at the end of the run
  int fail_cnt = 0;

  assign stages = {stage1_data, stage2_data, stage3_data};

  // Stage values one step later, by 1, 2 and 3 bits
  assign left_next = {{stage1_data[W-2:0], stage1_data[W-1]},
                      {stage2_data[W-3:0], stage2_data[W-1:W-2]},
                      {stage3_data[W-4:0], stage3_data[W-1:W-3]}};
  assign right_next = {{stage1_data[0], stage1_data[W-1:1]},
                       {stage2_data[1:0], stage2_data[W-1:2]},
                       {stage3_data[2:0], stage3_data[W-1:3]}};

  always_comb begin
    case (ctrl.ena)
      2'b00:   sel_q = data;
      2'b01:   sel_q = stage1_data;
      2'b10:   sel_q = stage2_data;
      default: sel_q = stage3_data;
    endcase
  end

  a_ctrl_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(ctrl))
    else begin
      fail_cnt++;
      $error("core controls carry unknown bits");
    end

  a_q_select: assert property (@(posedge clk) disable iff (!rst_n) q == sel_q)
    else begin
      fail_cnt++;
      $error("q differs from the source picked by ena");
    end

  a_load: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl.load |=> stages == $past({data, stage1_data, stage2_data}))
    else begin
      fail_cnt++;
      $error("load did not shift the stage pipeline");
    end

  a_left: assert property (@(posedge clk) disable iff (!rst_n)
    (!ctrl.load && ctrl.ena == 2'b01) |=> stages == $past(left_next))
    else begin
      fail_cnt++;
      $error("left step rotated the stages wrongly");
    end

  a_right: assert property (@(posedge clk) disable iff (!rst_n)
    (!ctrl.load && ctrl.ena == 2'b10) |=> stages == $past(right_next))
    else begin
      fail_cnt++;
      $error("right step rotated the stages wrongly");
    end

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (!ctrl.load && (ctrl.ena == 2'b00 || ctrl.ena == 2'b11)) |=> $stable(stages))
    else begin
      fail_cnt++;
      $error("stages changed while holding");
    end

endmodule

bind rot_core rot_props props_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .ctrl        (ctrl),
  .data        (data),
  .q           (q),
  .stage1_data (stage1_data),
  .stage2_data (stage2_data),
  .stage3_data (stage3_data)
);

/* verification/rot_tb.sv */
// Rotator subsystem testbench replaying APB patterns from a file and checking read data
`timescale 1ns/1ps

module rot_tb;

  import rot_pkg::*;

  localparam int    CLK_PERIOD   = 40;
  localparam int    POLL_LIMIT   = 300;
  localparam string PATTERN_FILE = "verification/rot_patterns.txt";

  logic     clk;
  logic     rst_n;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  int       n_lines = 0;

  rot_clk_gen #(
    .PERIOD       (CLK_PERIOD),
    .RESET_CYCLES (16)
  ) clk_gen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  rot_top dut_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at time %0t: %s got 0x%08h expected 0x%08h",
                          $time, name, got, exp));
    end
  endtask

  // One APB transfer after a random idle gap; response sampled mid access cycle
  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    apb_req_t    req;
    int unsigned gap;
    gap    = $urandom_range(3, 0);
    req    = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk);
    if (gap != 0) begin
      apb_req <= '0;
      repeat (gap) @(posedge clk);
    end
    apb_req <= req;
    @(posedge clk);
    req.penable = 1'b1;
    apb_req <= req;
    @(negedge clk);
    // No wait states, so every access cycle completes
    check_value("pready", 32'(apb_rsp.pready), 32'h1);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
  endtask

  // Read STATUS until busy drops
  task automatic poll_idle();
    logic [31:0] rdata;
    logic        err;
    time         start;
    start = $time;
    rdata = 32'h1;
    while (rdata[0]) begin
      if ($time - start > time'(POLL_LIMIT * CLK_PERIOD)) begin
        abort_run("STATUS still shows busy after 300 cycles of polling");
      end
      apb_xfer(1'b0, ADDR_STATUS, '0, rdata, err);
      check_value("pslverr of STATUS poll", 32'(err), 32'h0);
    end
  endtask

  // Watchdog sized from the pattern file length
  initial begin
    wait (n_lines > 0);
    #(n_lines * POLL_LIMIT * CLK_PERIOD);
    abort_run("Timeout: the pattern file did not finish in time");
  end

  initial begin
    int                fd;
    int                n;
    int                line_cnt;
    logic [7:0]        kind;
    logic [31:0]       addr;
    logic [31:0]       val;
    logic [31:0]       exp_err;
    logic [31:0]       rdata;
    logic              err;
    logic [8*128-1:0]  line_buf;
    apb_req <= '0;
    void'($urandom(97623));
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      abort_run("Cannot open the pattern file");
    end
    line_cnt = 0;
    while ($fgets(line_buf, fd) != 0) begin
      line_cnt++;
    end
    n_lines = line_cnt;
    $fclose(fd);
    fd = $fopen(PATTERN_FILE, "r");
    wait (rst_n === 1'b1);
    while ($fscanf(fd, " %c", kind) == 1) begin
      case (kind)
        "#": n = $fgets(line_buf, fd);
        "W": begin
          n = $fscanf(fd, "%h %h %h", addr, val, exp_err);
          if (n != 3) begin
            abort_run("Malformed W line in the pattern file");
          end
          apb_xfer(1'b1, addr[11:0], val, rdata, err);
          check_value($sformatf("pslverr of write to 0x%03h", addr[11:0]), 32'(err), exp_err);
        end
        "R": begin
          n = $fscanf(fd, "%h %h %h", addr, val, exp_err);
          if (n != 3) begin
            abort_run("Malformed R line in the pattern file");
          end
          apb_xfer(1'b0, addr[11:0], '0, rdata, err);
          check_value($sformatf("prdata at 0x%03h", addr[11:0]), rdata, val);
          check_value($sformatf("pslverr of read at 0x%03h", addr[11:0]), 32'(err), exp_err);
        end
        "P": poll_idle();
        default: abort_run($sformatf("Unknown command '%c' in the pattern file", kind));
      endcase
    end
    $fclose(fd);
    @(posedge clk);
    apb_req <= '0;
    repeat (2) @(posedge clk);
    if (dut_i.core_i.props_i.fail_cnt != 0) begin
      abort_run($sformatf("%0d core assertion failures during the run",
                          dut_i.core_i.props_i.fail_cnt));
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

/* verification/rot_patterns.txt */
# W addr data pslverr | R addr expected_data expected_pslverr | P polls STATUS until idle
# All numbers are hex; addresses are APB byte addresses
# Reset state
R 020 00000000 0
R 024 00000000 0
R 028 00000000 0
R 02C 00000000 0
R 018 00000000 0
# Staged word on q while idle_view is 0
W 000 DEADBEEF 0
W 004 01234567 0
W 008 89ABCDEF 0
W 00C FFFFFFFF 0
W 010 00000000 0
R 020 DEADBEEF 0
R 028 89ABCDEF 0
R 02C 0000000F 0
R 00C 0000000F 0
# Three loads move the first word (bits 0 and 99) into stage 3
W 000 00000001 0
W 004 00000000 0
W 008 00000000 0
W 00C 00000008 0
W 014 00000001 0
P
W 000 00000002 0
W 014 00000001 0
P
W 000 00000004 0
W 014 00000001 0
P
W 010 00000001 0
R 020 00000001 0
R 02C 00000008 0
# Left 1 step, left 11 steps, right 12 steps
W 014 00000102 0
P
R 020 0000000C 0
W 014 00000B02 0
P
R 024 00000018 0
W 014 00000C03 0
P
R 020 00000001 0
# Left 100 steps, then left 37 and right 37
W 014 00006402 0
P
R 02C 00000008 0
W 014 00002502 0
P
R 020 00000C00 0
W 014 00002503 0
P
R 020 00000001 0
# Refused accesses leave the state alone
W 014 0000FF02 0
W 014 00000001 1
R 018 00000001 0
P
R 028 00000003 0
W 020 12345678 1
R 020 00000000 0
W 030 00000001 1
R 030 00000000 1
R 018 00000000 0

/* vlog.f */
design/rot_pkg.sv
design/rot_regs.sv
design/rot_core.sv
design/rot_top.sv
verification/rot_clk_gen.sv
verification/rot_props.sv
verification/rot_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the rotator testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module rot_tb -o rot_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rot_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -qxF '>>> PASS' "$LOG"; then
  if [ $sim_status -eq 0 ]; then
    echo "Simulation passed"
    exit 0
  fi
fi

echo "Simulation failed"
exit 1
